/* sa_consts.svh */
`ifndef SA_CONSTS_SVH
`define SA_CONSTS_SVH

// grid size in processing elements
`define SA_ROWS 2
`define SA_COLS 2

// element width of A and B
`define SA_IWIDTH 8

// accumulator width, wide enough for SA_KMAX full scale products
`define SA_OWIDTH 24

// longest supported inner dimension and the width of its step index
`define SA_KMAX 8
`define SA_KBITS 3

`endif

/* sa_pkg.sv */
`include "sa_consts.svh"

package sa_pkg;

    localparam int SA_CBITS = (`SA_COLS > 1) ? $clog2(`SA_COLS) : 1;

    typedef logic [`SA_KBITS-1:0] sa_idx_t;
    typedef logic [`SA_KBITS:0] sa_klen_t;  // holds 1 to SA_KMAX
    typedef logic [SA_CBITS-1:0] sa_col_t;

    typedef logic signed [`SA_IWIDTH-1:0] sa_data_t;
    typedef logic signed [`SA_OWIDTH-1:0] sa_sum_t;

    // strobes that travel with the feature values along a row
    typedef struct packed {
        logic en_i;
        logic clr_i;
        logic en_w;
        logic clr_w;
        logic en_o;
        logic clr_o;
        logic mac_done;
        sa_idx_t idx;
    } sa_ctrl_t;

    typedef sa_ctrl_t [`SA_ROWS-1:0] sa_ctrl_vec_t;
    typedef sa_data_t [`SA_ROWS-1:0] sa_a_vec_t;
    typedef sa_data_t [`SA_COLS-1:0] sa_b_vec_t;
    typedef sa_sum_t [`SA_ROWS-1:0] sa_c_vec_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FEED,
        ST_FLUSH,
        ST_DRAIN
    } sa_state_t;

endpackage

/* sa_mul.sv */
`timescale 1ns/1ps
`include "sa_consts.svh"

module sa_mul (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic signed [`SA_IWIDTH-1:0]  a_i,
    input  logic signed [`SA_IWIDTH-1:0]  b_i,
    input  logic                          valid_i,
    input  logic [`SA_KBITS-1:0]          idx_i,
    output logic signed [2*`SA_IWIDTH-1:0] prod_o,
    output logic                          valid_o,
    output logic [`SA_KBITS-1:0]          idx_o
);

    logic [`SA_KBITS-1:0] last_idx_q;  // step index of the previous valid product

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prod_o     <= '0;
            valid_o    <= 1'b0;
            idx_o      <= '0;
            last_idx_q <= '0;
        end else begin
            prod_o  <= a_i * b_i;  // full width, no truncation
            valid_o <= valid_i;
            idx_o   <= idx_i;
            if (valid_i) begin
                last_idx_q <= idx_i;
            end
        end
    end

    // steps reach a cell in order and a new operation starts again at step zero
    a_idx_order: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (valid_i && idx_i != '0) |-> (idx_i == last_idx_q + `SA_KBITS'(1))
    );

endmodule

/* sa_acc.sv */
`timescale 1ns/1ps
`include "sa_consts.svh"

module sa_acc (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  logic                           clr_i,
    input  logic                           add_i,
    input  logic                           first_i,
    input  logic                           mac_done_i,
    input  logic signed [2*`SA_IWIDTH-1:0] prod_i,
    input  logic signed [`SA_OWIDTH-1:0]   sum_i,
    output logic signed [`SA_OWIDTH-1:0]   sum_o
);

    logic signed [`SA_OWIDTH-1:0] prod_ext;
    logic signed [`SA_OWIDTH-1:0] sum_q;
    logic signed [`SA_OWIDTH-1:0] skew_q;
    logic signed [`SA_OWIDTH-1:0] drain_q;

    assign prod_ext = {{(`SA_OWIDTH-2*`SA_IWIDTH){prod_i[2*`SA_IWIDTH-1]}}, prod_i};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sum_q <= '0;
        end else if (clr_i) begin
            sum_q <= '0;
        end else if (add_i) begin
            // step zero starts a new dot product
            sum_q <= first_i ? prod_ext : sum_q + prod_ext;
        end
    end

    // mac_done reaches each cell one cycle after its left neighbour, so the
    // incoming drain value waits one extra cycle in skew_q and is not lost
    // when this cell loads its own sum
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            skew_q  <= '0;
            drain_q <= '0;
        end else begin
            skew_q  <= sum_i;
            drain_q <= mac_done_i ? sum_q : skew_q;
        end
    end

    assign sum_o = drain_q;

    // clears come with start, long before the first product lands
    a_no_add_clr: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !(add_i && clr_i)
    );

endmodule

/* sa_pe.sv */
`timescale 1ns/1ps
`include "sa_consts.svh"

module sa_pe (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  sa_pkg::sa_ctrl_t              ctrl_i,
    output sa_pkg::sa_ctrl_t              ctrl_o,
    input  logic                          w_en_i,
    output logic                          w_en_o,
    input  logic signed [`SA_IWIDTH-1:0]  ifm_i,
    output logic signed [`SA_IWIDTH-1:0]  ifm_o,
    input  logic signed [`SA_IWIDTH-1:0]  wght_i,
    output logic signed [`SA_IWIDTH-1:0]  wght_o,
    input  logic signed [`SA_OWIDTH-1:0]  ofm_i,
    output logic signed [`SA_OWIDTH-1:0]  ofm_o
);

    import sa_pkg::*;

    sa_data_t                       ifm_q;
    sa_data_t                       wght_q;
    sa_ctrl_t                       ctrl_q;
    logic                           w_en_q;
    logic                           en_o_q;
    logic signed [2*`SA_IWIDTH-1:0] prod;
    logic                           prod_valid;
    sa_idx_t                        prod_idx;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ifm_q <= '0;
        end else if (ctrl_i.clr_i) begin
            ifm_q <= '0;
        end else if (ctrl_i.en_i) begin
            ifm_q <= ifm_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wght_q <= '0;
        end else if (ctrl_i.clr_w) begin
            wght_q <= '0;
        end else if (w_en_i) begin
            wght_q <= wght_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_q <= '0;
            w_en_q <= 1'b0;
            en_o_q <= 1'b0;
        end else begin
            ctrl_q <= ctrl_i;
            w_en_q <= w_en_i;
            en_o_q <= ctrl_q.en_o;  // lines up with the multiplier stage
        end
    end

    sa_mul i_mul (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .a_i      (ifm_q),
        .b_i      (wght_q),
        .valid_i  (ctrl_q.en_i),
        .idx_i    (ctrl_q.idx),
        .prod_o   (prod),
        .valid_o  (prod_valid),
        .idx_o    (prod_idx)
    );

    sa_acc i_acc (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .clr_i      (ctrl_q.clr_o),
        .add_i      (prod_valid && en_o_q),
        .first_i    (prod_idx == '0),
        .mac_done_i (ctrl_q.mac_done),
        .prod_i     (prod),
        .sum_i      (ofm_i),
        .sum_o      (ofm_o)
    );

    assign ctrl_o = ctrl_q;
    assign w_en_o = w_en_q;
    assign ifm_o  = ifm_q;
    assign wght_o = wght_q;

    // weight enables coming down the column must meet the row strobes of the same step
    a_wen_aligned: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        w_en_i == ctrl_i.en_w
    );

endmodule

/* sa_sequencer.sv */
`timescale 1ns/1ps
`include "sa_consts.svh"

module sa_sequencer (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 start_i,
    input  sa_pkg::sa_klen_t     k_len_i,
    input  logic                 step_i,
    input  sa_pkg::sa_a_vec_t    a_vec_i,
    input  sa_pkg::sa_b_vec_t    b_vec_i,
    output sa_pkg::sa_ctrl_vec_t row_ctrl_o,
    output sa_pkg::sa_a_vec_t    row_ifm_o,
    output sa_pkg::sa_b_vec_t    col_wght_o,
    output logic [`SA_COLS-1:0]  col_wen_o,
    output logic                 busy_o,
    output logic                 res_valid_o,
    output sa_pkg::sa_col_t      res_col_o,
    output logic                 done_o
);

    import sa_pkg::*;

    localparam int CNT_W = $clog2(2*`SA_COLS + `SA_ROWS + 2);

    sa_state_t          state_q;
    sa_klen_t           k_len_q;
    sa_idx_t            step_cnt_q;
    logic [CNT_W-1:0]   cnt_q;
    logic               md_q;
    logic               done_q;
    logic               strobe;
    logic               clr;
    sa_ctrl_t           ctrl_new;
    sa_ctrl_t           ctrl_pipe_q [`SA_ROWS];
    sa_a_vec_t          a_pipe_q [`SA_ROWS];
    sa_b_vec_t          b_pipe_q [`SA_COLS];
    logic [`SA_COLS-1:0] wen_pipe_q;

    assign strobe = (state_q == ST_FEED) && step_i;
    assign clr    = (state_q == ST_IDLE) && start_i;

    always_comb begin
        ctrl_new          = '0;
        ctrl_new.en_i     = strobe;
        ctrl_new.en_w     = strobe;
        ctrl_new.en_o     = strobe;
        ctrl_new.clr_i    = clr;
        ctrl_new.clr_w    = clr;
        ctrl_new.clr_o    = clr;
        ctrl_new.idx      = step_cnt_q;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= ST_IDLE;
            k_len_q    <= '0;
            step_cnt_q <= '0;
            cnt_q      <= '0;
            md_q       <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            md_q   <= 1'b0;
            done_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        k_len_q    <= k_len_i;
                        step_cnt_q <= '0;
                        state_q    <= ST_FEED;
                    end
                end
                ST_FEED: begin
                    if (step_i) begin
                        step_cnt_q <= step_cnt_q + 1'b1;
                        cnt_q      <= '0;
                        if (sa_klen_t'(step_cnt_q) == k_len_q - 1'b1) begin
                            state_q <= ST_FLUSH;
                        end
                    end
                end
                ST_FLUSH: begin
                    // let the last step reach the far corner and settle its sum
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(`SA_ROWS + `SA_COLS - 1)) begin
                        cnt_q   <= '0;
                        md_q    <= 1'b1;
                        state_q <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(2 * `SA_COLS)) begin
                        done_q  <= 1'b1;
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // row r is skewed r cycles and column c is skewed c cycles behind stage 0,
    // bubbles between strobes travel through the grid as idle slots
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int r = 0; r < `SA_ROWS; r++) begin
                ctrl_pipe_q[r] <= '0;
                a_pipe_q[r]    <= '0;
            end
            for (int c = 0; c < `SA_COLS; c++) begin
                b_pipe_q[c] <= '0;
            end
            wen_pipe_q <= '0;
        end else begin
            ctrl_pipe_q[0] <= ctrl_new;
            a_pipe_q[0]    <= a_vec_i;
            b_pipe_q[0]    <= b_vec_i;
            wen_pipe_q[0]  <= strobe;
            for (int r = 1; r < `SA_ROWS; r++) begin
                ctrl_pipe_q[r] <= ctrl_pipe_q[r-1];
                a_pipe_q[r]    <= a_pipe_q[r-1];
            end
            for (int c = 1; c < `SA_COLS; c++) begin
                b_pipe_q[c]   <= b_pipe_q[c-1];
                wen_pipe_q[c] <= wen_pipe_q[c-1];
            end
        end
    end

    always_comb begin
        for (int r = 0; r < `SA_ROWS; r++) begin
            row_ctrl_o[r]          = ctrl_pipe_q[r];
            row_ctrl_o[r].mac_done = md_q;  // all rows drain together, so no skew here
            row_ifm_o[r]           = a_pipe_q[r][r];
        end
        for (int c = 0; c < `SA_COLS; c++) begin
            col_wght_o[c] = b_pipe_q[c][c];
            col_wen_o[c]  = wen_pipe_q[c];
        end
    end

    // the rightmost column reaches the edge SA_COLS + 1 cycles after mac_done
    assign res_valid_o = (state_q == ST_DRAIN) && (cnt_q > CNT_W'(`SA_COLS))
                         && (cnt_q <= CNT_W'(2 * `SA_COLS));
    assign res_col_o   = sa_col_t'(2 * `SA_COLS - int'(cnt_q));
    assign busy_o      = (state_q != ST_IDLE);
    assign done_o      = done_q;

endmodule

/* sa_top.sv */
`timescale 1ns/1ps
`include "sa_consts.svh"

module sa_top (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              start_i,
    input  sa_pkg::sa_klen_t  k_len_i,
    input  logic              step_i,
    input  sa_pkg::sa_a_vec_t a_vec_i,
    input  sa_pkg::sa_b_vec_t b_vec_i,
    output logic              busy_o,
    output logic              res_valid_o,
    output sa_pkg::sa_col_t   res_col_o,
    output sa_pkg::sa_c_vec_t res_vec_o,
    output logic              done_o
);

    import sa_pkg::*;

    sa_ctrl_vec_t        row_ctrl;
    sa_a_vec_t           row_ifm;
    sa_b_vec_t           col_wght;
    logic [`SA_COLS-1:0] col_wen;

    // horizontal chains have SA_COLS + 1 taps, vertical ones SA_ROWS + 1
    sa_ctrl_t ctrl_h [`SA_ROWS][`SA_COLS+1];
    sa_data_t ifm_h  [`SA_ROWS][`SA_COLS+1];
    sa_sum_t  ofm_h  [`SA_ROWS][`SA_COLS+1];
    sa_data_t wght_v [`SA_ROWS+1][`SA_COLS];
    logic     wen_v  [`SA_ROWS+1][`SA_COLS];

    sa_sequencer i_seq (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .start_i     (start_i),
        .k_len_i     (k_len_i),
        .step_i      (step_i),
        .a_vec_i     (a_vec_i),
        .b_vec_i     (b_vec_i),
        .row_ctrl_o  (row_ctrl),
        .row_ifm_o   (row_ifm),
        .col_wght_o  (col_wght),
        .col_wen_o   (col_wen),
        .busy_o      (busy_o),
        .res_valid_o (res_valid_o),
        .res_col_o   (res_col_o),
        .done_o      (done_o)
    );

    for (genvar r = 0; r < `SA_ROWS; r++) begin : g_row
        assign ctrl_h[r][0] = row_ctrl[r];
        assign ifm_h[r][0]  = row_ifm[r];
        assign ofm_h[r][0]  = '0;  // nothing drains in from the left edge
        assign res_vec_o[r] = ofm_h[r][`SA_COLS];

        for (genvar c = 0; c < `SA_COLS; c++) begin : g_col
            if (r == 0) begin : g_top
                assign wght_v[0][c] = col_wght[c];
                assign wen_v[0][c]  = col_wen[c];
            end

            sa_pe i_pe (
                .clk      (clk),
                .arst_n_i (arst_n_i),
                .ctrl_i   (ctrl_h[r][c]),
                .ctrl_o   (ctrl_h[r][c+1]),
                .w_en_i   (wen_v[r][c]),
                .w_en_o   (wen_v[r+1][c]),
                .ifm_i    (ifm_h[r][c]),
                .ifm_o    (ifm_h[r][c+1]),
                .wght_i   (wght_v[r][c]),
                .wght_o   (wght_v[r+1][c]),
                .ofm_i    (ofm_h[r][c]),
                .ofm_o    (ofm_h[r][c+1])
            );
        end
    end

endmodule

/* tb_sa.sv */
`timescale 1ns/1ps
`include "sa_consts.svh"

module tb_sa;

    import sa_pkg::*;

    localparam int WAIT_LIMIT = 4 * `SA_KMAX + 64;

    logic      clk;
    logic      arst_n_i;
    logic      start_i;
    sa_klen_t  k_len_i;
    logic      step_i;
    sa_a_vec_t a_vec_i;
    sa_b_vec_t b_vec_i;
    logic      busy_o;
    logic      res_valid_o;
    sa_col_t   res_col_o;
    sa_c_vec_t res_vec_o;
    logic      done_o;

    logic [31:0] lfsr_q;
    logic [31:0] v;
    sa_data_t    a_m [`SA_ROWS][`SA_KMAX];
    sa_data_t    b_m [`SA_KMAX][`SA_COLS];
    int          exp_c [`SA_ROWS][`SA_COLS];
    int          res_cnt;
    int          done_cnt;
    logic        valid_d;
    int          val_errs;
    int          proto_errs;
    int          timeouts;
    bit          abort;

    sa_top i_dut (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .start_i     (start_i),
        .k_len_i     (k_len_i),
        .step_i      (step_i),
        .a_vec_i     (a_vec_i),
        .b_vec_i     (b_vec_i),
        .busy_o      (busy_o),
        .res_valid_o (res_valid_o),
        .res_col_o   (res_col_o),
        .res_vec_o   (res_vec_o),
        .done_o      (done_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // taps of x^32 + x^22 + x^2 + x + 1 and one step per bit taken
    task automatic rand_bits(input int n, output logic [31:0] val);
        logic fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = {val[30:0], fb};
        end
    endtask

    task automatic fill_random(input int k);
        logic [31:0] r_v;
        for (int kk = 0; kk < k; kk++) begin
            for (int r = 0; r < `SA_ROWS; r++) begin
                rand_bits(`SA_IWIDTH, r_v);
                a_m[r][kk] = r_v[`SA_IWIDTH-1:0];
            end
            for (int c = 0; c < `SA_COLS; c++) begin
                rand_bits(`SA_IWIDTH, r_v);
                b_m[kk][c] = r_v[`SA_IWIDTH-1:0];
            end
        end
    endtask

    task automatic fill_const(input int av, input int bv);
        for (int kk = 0; kk < `SA_KMAX; kk++) begin
            for (int r = 0; r < `SA_ROWS; r++) a_m[r][kk] = sa_data_t'(av);
            for (int c = 0; c < `SA_COLS; c++) b_m[kk][c] = sa_data_t'(bv);
        end
    endtask

    // plain integer C = A x B over the first k steps
    function automatic void compute_model(input int k);
        for (int r = 0; r < `SA_ROWS; r++) begin
            for (int c = 0; c < `SA_COLS; c++) begin
                exp_c[r][c] = 0;
                for (int kk = 0; kk < k; kk++) begin
                    exp_c[r][c] += int'(a_m[r][kk]) * int'(b_m[kk][c]);
                end
            end
        end
    endfunction

    task automatic check_column(input int col);
        if (res_col_o != sa_col_t'(col)) begin
            $display("[ERROR] %0t: res_col_o is %0d, expected %0d", $time, res_col_o, col);
            val_errs++;
        end
        for (int r = 0; r < `SA_ROWS; r++) begin
            if (res_vec_o[r] != exp_c[r][col]) begin
                $display("[ERROR] %0t: C[%0d][%0d] is %0d, expected %0d",
                         $time, r, col, res_vec_o[r], exp_c[r][col]);
                val_errs++;
            end
        end
    endtask

    // watches result and done pulses on the falling edge
    always @(negedge clk) begin
        if (res_valid_o) begin
            if (!busy_o) begin
                $display("[ERROR] %0t: busy_o low during result pulse %0d",
                         $time, res_cnt + 1);
                proto_errs++;
            end
            if (res_cnt >= `SA_COLS) begin
                $display("[ERROR] %0t: result pulse %0d, expected only %0d",
                         $time, res_cnt + 1, `SA_COLS);
                proto_errs++;
            end else begin
                check_column(`SA_COLS - 1 - res_cnt);  // rightmost column leaves first
            end
            res_cnt++;
        end
        if (done_o) begin
            if (done_cnt != 0 || res_cnt != `SA_COLS || !valid_d || busy_o) begin
                $display("[ERROR] %0t: done_o pulse %0d after %0d results, busy_o %0b",
                         $time, done_cnt + 1, res_cnt, busy_o);
                proto_errs++;
            end
            done_cnt++;
        end
        valid_d = res_valid_o;
    end

    // called right after a rising edge, returns right after one
    task automatic run_op(input int k, input bit gaps, input bit poke_start,
                          input int idle_after);
        logic [31:0] g;
        int          waited;
        if (abort) return;
        compute_model(k);
        res_cnt  = 0;
        done_cnt = 0;
        start_i <= 1'b1;
        k_len_i <= sa_klen_t'(k);
        @(posedge clk);
        start_i <= 1'b0;
        for (int kk = 0; kk < k; kk++) begin
            if (gaps) begin
                rand_bits(2, g);
                repeat (g) begin
                    rand_bits(32, v);  // junk on the data inputs while step_i is low
                    step_i  <= 1'b0;
                    a_vec_i <= v[2*`SA_IWIDTH-1:0];
                    b_vec_i <= v[31:32-2*`SA_IWIDTH];
                    @(posedge clk);
                end
            end
            step_i <= 1'b1;
            for (int r = 0; r < `SA_ROWS; r++) a_vec_i[r] <= a_m[r][kk];
            for (int c = 0; c < `SA_COLS; c++) b_vec_i[c] <= b_m[kk][c];
            @(posedge clk);
        end
        step_i <= 1'b0;
        if (poke_start) begin
            rand_bits(3, g);
            start_i <= 1'b1;  // lands in ST_FLUSH and must be ignored
            k_len_i <= sa_klen_t'(g[2:0] + 1);
            @(posedge clk);
            start_i <= 1'b0;
        end
        waited = 0;
        while (done_cnt == 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (done_cnt == 0) begin
            $display("timeout: no done_o pulse within %0d cycles after the last step", WAIT_LIMIT);
            timeouts++;
            abort = 1'b1;
            return;
        end
        repeat (idle_after) @(posedge clk);
    endtask

    initial begin
        arst_n_i   = 1'b0;
        start_i    = 1'b0;
        k_len_i    = '0;
        step_i     = 1'b0;
        a_vec_i    = '0;
        b_vec_i    = '0;
        lfsr_q     = 32'h46b6;
        res_cnt    = `SA_COLS;  // any pulse before the first operation is an error
        done_cnt   = 1;
        valid_d    = 1'b0;
        val_errs   = 0;
        proto_errs = 0;
        timeouts   = 0;
        abort      = 1'b0;
        repeat (10) @(posedge clk);
        arst_n_i <= 1'b1;
        repeat (6) begin
            @(negedge clk);
            if (busy_o || res_valid_o || done_o) begin
                $display("[ERROR] %0t: outputs active before start_i", $time);
                proto_errs++;
            end
        end
        @(posedge clk);
        for (int k = 1; k <= `SA_KMAX; k++) begin
            fill_random(k);
            run_op(k, 1'b0, 1'b0, 2);
        end
        for (int n = 0; n < 12; n++) begin
            rand_bits(3, v);
            fill_random(v[2:0] + 1);
            run_op(v[2:0] + 1, 1'b1, n[0], 1);
        end
        fill_const(-128, -128);
        run_op(`SA_KMAX, 1'b0, 1'b0, 1);
        fill_const(-128, 127);
        run_op(`SA_KMAX, 1'b0, 1'b0, 1);
        fill_const(127, 127);
        run_op(`SA_KMAX, 1'b1, 1'b0, 1);
        for (int n = 0; n < 6; n++) begin
            rand_bits(3, v);
            fill_random(v[2:0] + 1);
            run_op(v[2:0] + 1, n[1], 1'b0, 0);  // next start right after done_o
        end
        repeat (4) @(posedge clk);
        $display("value errors %0d, protocol errors %0d, timeouts %0d",
                 val_errs, proto_errs, timeouts);
        if (val_errs + proto_errs + timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+.
sa_pkg.sv
sa_mul.sv
sa_acc.sv
sa_pe.sv
sa_sequencer.sv
sa_top.sv
tb_sa.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_sa -o tb_sa_sim
./obj_dir/tb_sa_sim | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
